// ==== asym_fifo_pkg.sv ====
package asym_fifo_pkg;

   // port widths
   localparam int W_DATA_W   = 32;
   localparam int R_DATA_W   = 8;
   localparam int MIN_DATA_W = (W_DATA_W < R_DATA_W) ? W_DATA_W : R_DATA_W;
   localparam int MAX_DATA_W = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W;

   // one symmetric block per narrow slice of a wide item
   localparam int N_BLOCKS   = MAX_DATA_W / MIN_DATA_W;

   // ADDR_W counts narrow items
   localparam int ADDR_W     = 6;
   localparam int BLK_ADDR_W = ADDR_W - $clog2(N_BLOCKS);
   localparam int W_ADDR_W   = (W_DATA_W == MAX_DATA_W) ? BLK_ADDR_W : ADDR_W;
   localparam int R_ADDR_W   = (R_DATA_W == MAX_DATA_W) ? BLK_ADDR_W : ADDR_W;

   // fill level is kept in narrow units
   localparam int DEPTH      = 1 << ADDR_W;
   localparam int LEVEL_W    = $clog2(DEPTH) + 1;
   localparam int W_UNITS    = W_DATA_W / MIN_DATA_W;
   localparam int R_UNITS    = R_DATA_W / MIN_DATA_W;

   typedef logic [W_DATA_W-1:0] w_data_t;
   typedef logic [R_DATA_W-1:0] r_data_t;
   typedef logic [W_ADDR_W-1:0] w_addr_t;
   typedef logic [R_ADDR_W-1:0] r_addr_t;
   typedef logic [LEVEL_W-1:0]  level_t;

endpackage

// ==== ram_2p.sv ====
`timescale 1ns/100ps

module ram_2p #(
   parameter int DATA_W = 8,
   parameter int ADDR_W = 4
) (
   input  logic              clk,
   input  logic              w_en,
   input  logic [ADDR_W-1:0] w_addr,
   input  logic [DATA_W-1:0] w_data,
   input  logic              r_en,
   input  logic [ADDR_W-1:0] r_addr,
   output logic [DATA_W-1:0] r_data
);

   localparam int WORDS = 1 << ADDR_W;

   logic [DATA_W-1:0] mem [0:WORDS-1];

   // synchronous write
   always_ff @(posedge clk) begin
      if (w_en) begin
         mem[w_addr] <= w_data;
      end
   end

   // registered read, output holds while r_en is low
   always_ff @(posedge clk) begin
      if (r_en) begin
         r_data <= mem[r_addr];
      end
   end

endmodule

// ==== ram_2p_asym.sv ====
`timescale 1ns/100ps

module ram_2p_asym (
   input  logic                   clk,
   input  logic                   w_en,
   input  asym_fifo_pkg::w_addr_t w_addr,
   input  asym_fifo_pkg::w_data_t w_data,
   input  logic                   r_en,
   input  asym_fifo_pkg::r_addr_t r_addr,
   output asym_fifo_pkg::r_data_t r_data
);

   import asym_fifo_pkg::*;

   // bits that pick one block out of N_BLOCKS
   localparam int SEL_W = $clog2(N_BLOCKS);

   // per-block write side
   logic                  en_wr   [N_BLOCKS];
   logic [MIN_DATA_W-1:0] data_wr [N_BLOCKS];
   logic [BLK_ADDR_W-1:0] addr_wr [N_BLOCKS];

   // per-block read side
   logic [BLK_ADDR_W-1:0] addr_rd [N_BLOCKS];
   logic [MIN_DATA_W-1:0] data_rd [N_BLOCKS];

   for (genvar b = 0; b < N_BLOCKS; b++) begin : g_blk
      ram_2p #(
         .DATA_W(MIN_DATA_W),
         .ADDR_W(BLK_ADDR_W)
      ) u_ram (
         .clk   (clk),
         .w_en  (en_wr[b]),
         .w_addr(addr_wr[b]),
         .w_data(data_wr[b]),
         .r_en  (r_en),
         .r_addr(addr_rd[b]),
         .r_data(data_rd[b])
      );
   end

   if (W_DATA_W > R_DATA_W) begin : g_wide_write
      // block of the pending read, kept until the data leave the blocks
      logic [SEL_W-1:0] r_sel;

      // every block takes its own slice of the word
      always_comb begin
         for (int i = 0; i < N_BLOCKS; i++) begin
            en_wr[i]   = w_en;
            data_wr[i] = w_data[i*MIN_DATA_W +: MIN_DATA_W];
            addr_wr[i] = w_addr[W_ADDR_W-1 -: BLK_ADDR_W];
         end
      end

      // high read bits address all blocks alike
      always_comb begin
         for (int i = 0; i < N_BLOCKS; i++) begin
            addr_rd[i] = r_addr[R_ADDR_W-1 -: BLK_ADDR_W];
         end
      end

      always_ff @(posedge clk) begin
         if (r_en) begin
            r_sel <= r_addr[SEL_W-1:0];
         end
      end

      assign r_data = data_rd[r_sel];

   end else if (W_DATA_W < R_DATA_W) begin : g_wide_read
      // low write bits choose the one block that is written
      always_comb begin
         for (int i = 0; i < N_BLOCKS; i++) begin
            en_wr[i]   = w_en && (w_addr[SEL_W-1:0] == SEL_W'(i));
            data_wr[i] = w_data;
            addr_wr[i] = w_addr[W_ADDR_W-1 -: BLK_ADDR_W];
         end
      end

      // all blocks read together and are packed side by side
      always_comb begin
         for (int i = 0; i < N_BLOCKS; i++) begin
            addr_rd[i] = r_addr[R_ADDR_W-1 -: BLK_ADDR_W];
            r_data[i*MIN_DATA_W +: MIN_DATA_W] = data_rd[i];
         end
      end

   end else begin : g_equal
      // single block, straight through
      always_comb begin
         en_wr[0]   = w_en;
         data_wr[0] = w_data;
         addr_wr[0] = w_addr;
         addr_rd[0] = r_addr;
      end

      assign r_data = data_rd[0];
   end

endmodule

// ==== fifo_ctrl.sv ====
`timescale 1ns/100ps

module fifo_ctrl (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   push,
   input  logic                   pop,
   output logic                   w_en,
   output asym_fifo_pkg::w_addr_t w_addr,
   output logic                   r_en,
   output asym_fifo_pkg::r_addr_t r_addr,
   output logic                   r_valid,
   output logic                   full,
   output logic                   empty,
   output asym_fifo_pkg::level_t  level
);

   import asym_fifo_pkg::*;

   logic    accept_push;
   logic    accept_pop;
   w_addr_t w_ptr;
   r_addr_t r_ptr;
   level_t  level_next;
   logic    full_next;
   logic    empty_next;

   // strobes are judged against the registered flags only
   assign accept_push = push && !full;
   assign accept_pop  = pop && !empty;

   // the RAM is driven straight from the pointers
   assign w_en   = accept_push;
   assign w_addr = w_ptr;
   assign r_en   = accept_pop;
   assign r_addr = r_ptr;

   // a push and a pop in one cycle may both count
   always_comb begin
      level_next = level;
      if (accept_push) begin
         level_next = level_next + level_t'(W_UNITS);
      end
      if (accept_pop) begin
         level_next = level_next - level_t'(R_UNITS);
      end
   end

   // full means no room left for a whole word
   assign full_next  = level_next > level_t'(DEPTH - W_UNITS);
   assign empty_next = level_next < level_t'(R_UNITS);

   // pointers wrap at the power-of-two depth
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         w_ptr <= '0;
      end else if (accept_push) begin
         w_ptr <= w_ptr + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         r_ptr <= '0;
      end else if (accept_pop) begin
         r_ptr <= r_ptr + 1'b1;
      end
   end

   // level and flags
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         level <= '0;
         full  <= 1'b0;
         empty <= 1'b1;
      end else begin
         level <= level_next;
         full  <= full_next;
         empty <= empty_next;
      end
   end

   // byte leaves the RAM one cycle after the accepted pop
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         r_valid <= 1'b0;
      end else begin
         r_valid <= accept_pop;
      end
   end

endmodule

// ==== asym_fifo.sv ====
`timescale 1ns/100ps

module asym_fifo (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   push,
   input  asym_fifo_pkg::w_data_t w_data,
   input  logic                   pop,
   output asym_fifo_pkg::r_data_t r_data,
   output logic                   r_valid,
   output logic                   full,
   output logic                   empty,
   output asym_fifo_pkg::level_t  level
);

   import asym_fifo_pkg::*;

   // controller to storage
   logic    w_en;
   w_addr_t w_addr;
   logic    r_en;
   r_addr_t r_addr;

   fifo_ctrl u_ctrl (
      .clk    (clk),
      .rst_n  (rst_n),
      .push   (push),
      .pop    (pop),
      .w_en   (w_en),
      .w_addr (w_addr),
      .r_en   (r_en),
      .r_addr (r_addr),
      .r_valid(r_valid),
      .full   (full),
      .empty  (empty),
      .level  (level)
   );

   // words in, bytes out
   ram_2p_asym u_ram (
      .clk   (clk),
      .w_en  (w_en),
      .w_addr(w_addr),
      .w_data(w_data),
      .r_en  (r_en),
      .r_addr(r_addr),
      .r_data(r_data)
   );

endmodule

// ==== asym_fifo_assertions.sv ====
`timescale 1ns/100ps

module asym_fifo_assertions (
   input logic                  clk,
   input logic                  rst_n,
   input logic                  push,
   input logic                  pop,
   input logic                  r_valid,
   input logic                  full,
   input logic                  empty,
   input asym_fifo_pkg::level_t level
);

   import asym_fifo_pkg::*;

   // failed assertions so far
   int fail_count = 0;

   a_flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n) !(full && empty))
      else begin
         fail_count++;
         $error("full and empty are high together");
      end

   a_level_bound: assert property (@(posedge clk) disable iff (!rst_n) level <= level_t'(DEPTH))
      else begin
         fail_count++;
         $error("level exceeds the FIFO depth");
      end

   // a byte only follows a pop that found data
   a_valid_after_pop: assert property (@(posedge clk) disable iff (!rst_n)
      r_valid |-> $past(pop && !empty))
      else begin
         fail_count++;
         $error("r_valid without an accepted pop");
      end

   a_level_idle: assert property (@(posedge clk) disable iff (!rst_n)
      (!push && !pop) |=> $stable(level))
      else begin
         fail_count++;
         $error("level changed without a strobe");
      end

endmodule

bind asym_fifo asym_fifo_assertions u_assertions (
   .clk    (clk),
   .rst_n  (rst_n),
   .push   (push),
   .pop    (pop),
   .r_valid(r_valid),
   .full   (full),
   .empty  (empty),
   .level  (level)
);

// ==== asym_fifo_tb.sv ====
`timescale 1ns/100ps

module asym_fifo_tb;

   import asym_fifo_pkg::*;

   localparam int MAX_CYCLES  = 2000;
   localparam int RAND_CYCLES = 600;

   logic    clk;
   logic    rst_n;
   logic    push;
   w_data_t w_data;
   logic    pop;
   r_data_t r_data;
   logic    r_valid;
   logic    full;
   logic    empty;
   level_t  level;

   // reference model, one entry per byte still in the FIFO
   r_data_t model_q[$];
   int      model_level;
   logic    exp_valid;
   r_data_t exp_byte;

   int      errors;
   int      cycles;
   int      seed;
   string   test_name;

   asym_fifo dut (
      .clk    (clk),
      .rst_n  (rst_n),
      .push   (push),
      .w_data (w_data),
      .pop    (pop),
      .r_data (r_data),
      .r_valid(r_valid),
      .full   (full),
      .empty  (empty),
      .level  (level)
   );

   always #10 clk = ~clk;

   // byte k of a word, low byte first
   function automatic r_data_t word_byte(input w_data_t word, input int k);
      return word[8*k +: 8];
   endfunction

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (actual !== expected) begin
         errors++;
         $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
      end
   endtask

   // apply one cycle of strobes, return just after the edge that takes them
   task automatic drive(input logic p, input w_data_t d, input logic q);
      push   = p;
      w_data = d;
      pop    = q;
      @(posedge clk);
      #1;
   endtask

   // model follows the same acceptance rules on its own level
   always @(posedge clk) begin : model_update
      logic acc_push;
      logic acc_pop;
      if (!rst_n) begin
         model_q.delete();
         model_level = 0;
         exp_valid   = 1'b0;
      end else begin
         acc_push  = push && (model_level <= DEPTH - W_UNITS);
         acc_pop   = pop && (model_level >= R_UNITS);
         exp_valid = acc_pop;
         if (acc_pop) begin
            exp_byte    = model_q.pop_front();
            model_level = model_level - R_UNITS;
         end
         if (acc_push) begin
            for (int k = 0; k < W_UNITS; k++) begin
               model_q.push_back(word_byte(w_data, k));
            end
            model_level = model_level + W_UNITS;
         end
      end
   end

   // outputs are settled by the falling edge
   always @(negedge clk) begin
      if (rst_n) begin
         check({test_name, " level"}, model_level, level);
         check({test_name, " full"}, model_level > DEPTH - W_UNITS, full);
         check({test_name, " empty"}, model_level < R_UNITS, empty);
         check({test_name, " r_valid"}, exp_valid, r_valid);
         if (exp_valid) begin
            check({test_name, " r_data"}, exp_byte, r_data);
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         errors++;
         $display("test timed out after %0d cycles", cycles);
         $display("%0d errors", errors);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   initial begin
      w_data_t     word;
      logic [31:0] rnd;
      logic        p;
      logic        q;
      seed        = 67348;
      errors      = 0;
      cycles      = 0;
      clk         = 1'b0;
      rst_n       = 1'b0;
      push        = 1'b0;
      pop         = 1'b0;
      w_data      = '0;
      model_level = 0;
      exp_valid   = 1'b0;
      exp_byte    = '0;
      test_name   = "reset";
      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;

      check("reset level", 0, level);
      check("reset empty", 1, empty);
      check("reset full", 0, full);
      check("reset r_valid", 0, r_valid);
      drive(1'b0, '0, 1'b1);
      check("reset pop r_valid", 0, r_valid);
      drive(1'b0, '0, 1'b0);

      test_name = "byte_order";
      word = 32'h4d3c2b1a;
      drive(1'b1, word, 1'b0);
      check("byte_order level", 4, level);
      for (int k = 0; k < 4; k++) begin
         drive(1'b0, '0, 1'b1);
         check("byte_order level", 3 - k, level);
         check("byte_order r_valid", 1, r_valid);
         check("byte_order r_data", word_byte(word, k), r_data);
      end
      drive(1'b0, '0, 1'b0);

      // bytes of the 16 words count 0 to 63 in pop order
      test_name = "fill";
      for (int i = 0; i < 16; i++) begin
         drive(1'b1, 32'h03020100 + i * 32'h04040404, 1'b0);
         check("fill level", 4 * (i + 1), level);
         check("fill full", i == 15, full);
      end
      drive(1'b1, 32'hdeadbeef, 1'b0);
      check("fill overflow level", 64, level);
      for (int j = 0; j < 64; j++) begin
         drive(1'b0, '0, 1'b1);
         check("fill r_valid", 1, r_valid);
         check("fill r_data", j, r_data);
      end
      drive(1'b0, '0, 1'b0);
      check("fill drained empty", 1, empty);

      test_name = "underflow";
      repeat (3) begin
         drive(1'b0, '0, 1'b1);
         check("underflow r_valid", 0, r_valid);
         check("underflow level", 0, level);
      end
      word = $random(seed);
      drive(1'b1, word, 1'b0);
      for (int k = 0; k < 4; k++) begin
         drive(1'b0, '0, 1'b1);
         check("underflow r_data", word_byte(word, k), r_data);
      end
      drive(1'b0, '0, 1'b0);

      // filling first half, draining second half
      test_name = "random";
      for (int i = 0; i < RAND_CYCLES; i++) begin
         rnd = $random(seed);
         if (i < RAND_CYCLES / 2) begin
            p = rnd[2:0] < 3'd3;
         end else begin
            p = rnd[2:0] == 3'd0;
         end
         q    = rnd[4:3] != 2'b00;
         word = $random(seed);
         drive(p, word, q);
      end
      repeat (DEPTH) drive(1'b0, '0, 1'b1);
      repeat (2) drive(1'b0, '0, 1'b0);
      check("random drained empty", 1, empty);

      errors += dut.u_assertions.fail_count;
      $display("%0d errors in %0d cycles", errors, cycles);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

// ==== all.f ====
asym_fifo_pkg.sv
ram_2p.sv
ram_2p_asym.sv
fifo_ctrl.sv
asym_fifo.sv
asym_fifo_assertions.sv
asym_fifo_tb.sv
